// ==== rtl/bank_pkg.sv ====
`default_nettype none

package bank_pkg;

  // Bus side of each port
  localparam int unsigned NUM_PORTS        = 2;
  localparam int unsigned BUS_ADDR_WIDTH   = 16;
  localparam int unsigned BUS_DATA_WIDTH   = 64;
  localparam int unsigned BUS_STRB_WIDTH   = BUS_DATA_WIDTH / 8;
  // Byte offset bits inside one bus word
  localparam int unsigned BUS_OFFSET_WIDTH = $clog2(BUS_STRB_WIDTH);

  // Memory side, one bank word per lane
  localparam int unsigned MEM_DATA_WIDTH   = 32;
  localparam int unsigned MEM_STRB_WIDTH   = MEM_DATA_WIDTH / 8;
  localparam int unsigned NUM_LANES        = BUS_DATA_WIDTH / MEM_DATA_WIDTH;
  localparam int unsigned NUM_BANKS        = 4;
  localparam int unsigned BANK_SEL_WIDTH   = 2;
  // Bank index sits right above the byte offset of a bank word
  localparam int unsigned BANK_SEL_OFFSET  = 2;
  localparam int unsigned MEM_ADDR_WIDTH   = 8;
  localparam int unsigned MEM_LATENCY      = 1;

  // Crossbar inputs, all lanes of all ports
  localparam int unsigned XBAR_INPUTS      = NUM_PORTS * NUM_LANES;
  localparam int unsigned XBAR_IDX_WIDTH   = $clog2(XBAR_INPUTS);

  typedef logic [BANK_SEL_WIDTH-1:0] bank_sel_t;
  typedef logic [XBAR_IDX_WIDTH-1:0] xbar_idx_t;

  // Wishbone classic, master to slave
  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [BUS_ADDR_WIDTH-1:0] adr;
    logic [BUS_DATA_WIDTH-1:0] dat;
    logic [BUS_STRB_WIDTH-1:0] sel;
  } wb_req_t;

  // Wishbone classic, slave to master
  typedef struct packed {
    logic                      ack;
    logic [BUS_DATA_WIDTH-1:0] dat;
  } wb_rsp_t;

  // One bank access as it travels through the crossbar
  typedef struct packed {
    logic [MEM_ADDR_WIDTH-1:0] addr;
    logic                      we;
    logic [MEM_DATA_WIDTH-1:0] wdata;
    logic [MEM_STRB_WIDTH-1:0] be;
  } bank_req_t;

  // Return route of one lane, shifted along with the read latency
  typedef struct packed {
    bank_sel_t sel;
    logic      valid;
  } lane_route_t;

endpackage

`default_nettype wire

// ==== rtl/wb_bank_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_bank_port (
  input  logic                                                       clk_i,
  input  logic                                                       reset_i,
  input  bank_pkg::wb_req_t                                          wb_req_i,
  output bank_pkg::wb_rsp_t                                          wb_rsp_o,
  output logic                [bank_pkg::NUM_LANES-1:0]              lane_valid_o,
  output bank_pkg::bank_sel_t [bank_pkg::NUM_LANES-1:0]              lane_sel_o,
  output bank_pkg::bank_req_t [bank_pkg::NUM_LANES-1:0]              lane_req_o,
  input  logic                [bank_pkg::NUM_LANES-1:0]              lane_gnt_i,
  input  logic                [bank_pkg::NUM_LANES-1:0]              lane_rvalid_i,
  input  logic [bank_pkg::NUM_LANES-1:0][bank_pkg::MEM_DATA_WIDTH-1:0] lane_rdata_i
);

  // Access in progress, lanes requesting or waiting for data
  logic                                  active_q;
  logic                                  ack_q;
  // Lane has been granted by its bank
  logic [bank_pkg::NUM_LANES-1:0]        gnt_q;
  // Lane finished, write granted or read data captured
  logic [bank_pkg::NUM_LANES-1:0]        done_q;
  logic [bank_pkg::NUM_LANES-1:0]        done_now;
  logic [bank_pkg::NUM_LANES-1:0]        done_all;
  logic [bank_pkg::BUS_DATA_WIDTH-1:0]   rdata_q;
  logic                                  start;

  // New access only once the previous ack has been seen by the master
  assign start = wb_req_i.cyc & wb_req_i.stb & ~active_q & ~ack_q;

  for (genvar j = 0; j < bank_pkg::NUM_LANES; j++) begin : gen_lane
    logic [bank_pkg::BUS_ADDR_WIDTH-1:0] lane_addr;

    // Bus word aligned address plus the lane's byte offset
    assign lane_addr = {wb_req_i.adr[bank_pkg::BUS_ADDR_WIDTH-1:bank_pkg::BUS_OFFSET_WIDTH],
                        {bank_pkg::BUS_OFFSET_WIDTH{1'b0}}}
                     + bank_pkg::BUS_ADDR_WIDTH'(j * bank_pkg::MEM_STRB_WIDTH);

    // Bank index interleaves consecutive bank words across banks
    assign lane_sel_o[j] = lane_addr[bank_pkg::BANK_SEL_OFFSET +: bank_pkg::BANK_SEL_WIDTH];

    // Request fields follow the bus, which holds them until ack
    assign lane_req_o[j].addr  = lane_addr[bank_pkg::BANK_SEL_OFFSET + bank_pkg::BANK_SEL_WIDTH
                                           +: bank_pkg::MEM_ADDR_WIDTH];
    assign lane_req_o[j].we    = wb_req_i.we;
    assign lane_req_o[j].wdata = wb_req_i.dat[j*bank_pkg::MEM_DATA_WIDTH +: bank_pkg::MEM_DATA_WIDTH];
    assign lane_req_o[j].be    = wb_req_i.sel[j*bank_pkg::MEM_STRB_WIDTH +: bank_pkg::MEM_STRB_WIDTH];

    // Requesting until the bank grants it
    assign lane_valid_o[j] = active_q & ~gnt_q[j];

    // Write is done at grant, read when its data comes back
    assign done_now[j] = active_q & (wb_req_i.we ? lane_gnt_i[j]
                                                 : gnt_q[j] & lane_rvalid_i[j]);
  end

  assign done_all = done_q | done_now;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q <= 1'b0;
      ack_q    <= 1'b0;
      gnt_q    <= '0;
      done_q   <= '0;
    end else begin
      // Single cycle ack pulse
      ack_q <= 1'b0;
      if (start) begin
        active_q <= 1'b1;
      end else if (active_q) begin
        if (&done_all) begin
          // Both lanes complete, ack and get ready for the next access
          ack_q    <= 1'b1;
          active_q <= 1'b0;
          gnt_q    <= '0;
          done_q   <= '0;
        end else begin
          gnt_q  <= gnt_q | lane_gnt_i;
          done_q <= done_all;
        end
      end
    end
  end

  // Each lane fills its own half of the read word
  always_ff @(posedge clk_i) begin
    for (int unsigned j = 0; j < bank_pkg::NUM_LANES; j++) begin
      if (active_q && !wb_req_i.we && gnt_q[j] && lane_rvalid_i[j]) begin
        rdata_q[j*bank_pkg::MEM_DATA_WIDTH +: bank_pkg::MEM_DATA_WIDTH] <= lane_rdata_i[j];
      end
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdata_q;

endmodule

`default_nettype wire

// ==== rtl/bank_rr_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_rr_arbiter (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic [bank_pkg::XBAR_INPUTS-1:0]    req_i,
  input  logic                                gnt_i,
  output bank_pkg::xbar_idx_t                 idx_o,
  output logic                                valid_o
);

  // Search starts here, moves past the last winner
  bank_pkg::xbar_idx_t ptr_q;
  // Choice held while the bank stalls
  logic                lock_q;
  bank_pkg::xbar_idx_t lock_idx_q;
  bank_pkg::xbar_idx_t rr_idx;
  logic                rr_valid;

  // First requester at or after the pointer
  always_comb begin
    bank_pkg::xbar_idx_t cand;
    rr_idx   = ptr_q;
    rr_valid = 1'b0;
    for (int unsigned k = 0; k < bank_pkg::XBAR_INPUTS; k++) begin
      cand = ptr_q + bank_pkg::xbar_idx_t'(k);
      if (!rr_valid && req_i[cand]) begin
        rr_idx   = cand;
        rr_valid = 1'b1;
      end
    end
  end

  assign idx_o   = lock_q ? lock_idx_q : rr_idx;
  assign valid_o = lock_q ? req_i[lock_idx_q] : rr_valid;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      // Lock in while the request is stalled
      lock_q     <= valid_o & ~gnt_i;
      lock_idx_q <= idx_o;
      if (valid_o && gnt_i) begin
        ptr_q <= idx_o + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/bank_xbar.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_xbar (
  input  logic                                             clk_i,
  input  logic                                             reset_i,
  input  logic                [bank_pkg::XBAR_INPUTS-1:0]  in_valid_i,
  input  bank_pkg::bank_sel_t [bank_pkg::XBAR_INPUTS-1:0]  in_sel_i,
  input  bank_pkg::bank_req_t [bank_pkg::XBAR_INPUTS-1:0]  in_req_i,
  output logic                [bank_pkg::XBAR_INPUTS-1:0]  in_gnt_o,
  output logic                [bank_pkg::NUM_BANKS-1:0]    mem_req_o,
  output bank_pkg::bank_req_t [bank_pkg::NUM_BANKS-1:0]    mem_bank_o,
  input  logic                [bank_pkg::NUM_BANKS-1:0]    mem_gnt_i
);

  // Which inputs want which bank
  logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::XBAR_INPUTS-1:0] bank_req;
  // Winning input per bank
  bank_pkg::xbar_idx_t [bank_pkg::NUM_BANKS-1:0]             bank_idx;
  // Per input, which bank accepted it this cycle
  logic [bank_pkg::XBAR_INPUTS-1:0][bank_pkg::NUM_BANKS-1:0] gnt_matrix;

  for (genvar b = 0; b < bank_pkg::NUM_BANKS; b++) begin : gen_bank
    for (genvar i = 0; i < bank_pkg::XBAR_INPUTS; i++) begin : gen_input
      // Decode the lane's bank index
      assign bank_req[b][i] = in_valid_i[i] & (in_sel_i[i] == bank_pkg::bank_sel_t'(b));

      // Grant only the winner, and only when the access really happens
      assign gnt_matrix[i][b] = mem_req_o[b] & mem_gnt_i[b]
                              & (bank_idx[b] == bank_pkg::xbar_idx_t'(i));
    end

    bank_rr_arbiter u_arb (
      .clk_i   ( clk_i        ),
      .reset_i ( reset_i      ),
      .req_i   ( bank_req[b]  ),
      .gnt_i   ( mem_gnt_i[b] ),
      .idx_o   ( bank_idx[b]  ),
      .valid_o ( mem_req_o[b] )
    );

    // Winner's payload goes to the bank
    assign mem_bank_o[b] = in_req_i[bank_idx[b]];
  end

  // Each lane targets a single bank, so at most one bit is set
  for (genvar i = 0; i < bank_pkg::XBAR_INPUTS; i++) begin : gen_gnt
    assign in_gnt_o[i] = |gnt_matrix[i];
  end

endmodule

`default_nettype wire

// ==== rtl/read_return_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_return_pipe (
  input  logic                                                         clk_i,
  input  logic                                                         reset_i,
  input  logic                [bank_pkg::NUM_LANES-1:0]                lane_gnt_i,
  input  bank_pkg::bank_sel_t [bank_pkg::NUM_LANES-1:0]                lane_sel_i,
  input  logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::MEM_DATA_WIDTH-1:0] mem_rdata_i,
  output logic                [bank_pkg::NUM_LANES-1:0]                lane_rvalid_o,
  output logic [bank_pkg::NUM_LANES-1:0][bank_pkg::MEM_DATA_WIDTH-1:0] lane_rdata_o
);

  // One stage per cycle of bank read latency
  bank_pkg::lane_route_t [bank_pkg::NUM_LANES-1:0] route_q [bank_pkg::MEM_LATENCY];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int unsigned s = 0; s < bank_pkg::MEM_LATENCY; s++) begin
        route_q[s] <= '0;
      end
    end else begin
      // Capture the route in the grant cycle
      for (int unsigned j = 0; j < bank_pkg::NUM_LANES; j++) begin
        route_q[0][j].sel   <= lane_sel_i[j];
        route_q[0][j].valid <= lane_gnt_i[j];
      end
      // Older routes move one stage on
      for (int unsigned s = 1; s < bank_pkg::MEM_LATENCY; s++) begin
        route_q[s] <= route_q[s-1];
      end
    end
  end

  for (genvar j = 0; j < bank_pkg::NUM_LANES; j++) begin : gen_lane
    // Last stage lines up with the bank's read data
    assign lane_rvalid_o[j] = route_q[bank_pkg::MEM_LATENCY-1][j].valid;
    assign lane_rdata_o[j]  = mem_rdata_i[route_q[bank_pkg::MEM_LATENCY-1][j].sel];
  end

endmodule

`default_nettype wire

// ==== rtl/banked_mem_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module banked_mem_ctrl (
  input  logic                                                         clk_i,
  input  logic                                                         reset_i,
  input  bank_pkg::wb_req_t   [bank_pkg::NUM_PORTS-1:0]                wb_req_i,
  output bank_pkg::wb_rsp_t   [bank_pkg::NUM_PORTS-1:0]                wb_rsp_o,
  output logic                [bank_pkg::NUM_BANKS-1:0]                mem_req_o,
  output bank_pkg::bank_req_t [bank_pkg::NUM_BANKS-1:0]                mem_bank_o,
  input  logic                [bank_pkg::NUM_BANKS-1:0]                mem_gnt_i,
  input  logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::MEM_DATA_WIDTH-1:0] mem_rdata_i
);

  // Flattened lanes, port 0 lanes first
  logic                [bank_pkg::XBAR_INPUTS-1:0] lane_valid;
  logic                [bank_pkg::XBAR_INPUTS-1:0] lane_gnt;
  bank_pkg::bank_sel_t [bank_pkg::XBAR_INPUTS-1:0] lane_sel;
  bank_pkg::bank_req_t [bank_pkg::XBAR_INPUTS-1:0] lane_req;

  for (genvar p = 0; p < bank_pkg::NUM_PORTS; p++) begin : gen_port
    logic [bank_pkg::NUM_LANES-1:0]                               rvalid;
    logic [bank_pkg::NUM_LANES-1:0][bank_pkg::MEM_DATA_WIDTH-1:0] rdata;

    wb_bank_port u_port (
      .clk_i         ( clk_i                                                  ),
      .reset_i       ( reset_i                                                ),
      .wb_req_i      ( wb_req_i[p]                                            ),
      .wb_rsp_o      ( wb_rsp_o[p]                                            ),
      .lane_valid_o  ( lane_valid[p*bank_pkg::NUM_LANES +: bank_pkg::NUM_LANES] ),
      .lane_sel_o    ( lane_sel[p*bank_pkg::NUM_LANES +: bank_pkg::NUM_LANES]   ),
      .lane_req_o    ( lane_req[p*bank_pkg::NUM_LANES +: bank_pkg::NUM_LANES]   ),
      .lane_gnt_i    ( lane_gnt[p*bank_pkg::NUM_LANES +: bank_pkg::NUM_LANES]   ),
      .lane_rvalid_i ( rvalid                                                 ),
      .lane_rdata_i  ( rdata                                                  )
    );

    // Read data returns to the lanes that were granted
    read_return_pipe u_pipe (
      .clk_i         ( clk_i                                                  ),
      .reset_i       ( reset_i                                                ),
      .lane_gnt_i    ( lane_gnt[p*bank_pkg::NUM_LANES +: bank_pkg::NUM_LANES]   ),
      .lane_sel_i    ( lane_sel[p*bank_pkg::NUM_LANES +: bank_pkg::NUM_LANES]   ),
      .mem_rdata_i   ( mem_rdata_i                                            ),
      .lane_rvalid_o ( rvalid                                                 ),
      .lane_rdata_o  ( rdata                                                  )
    );
  end

  bank_xbar u_xbar (
    .clk_i      ( clk_i      ),
    .reset_i    ( reset_i    ),
    .in_valid_i ( lane_valid ),
    .in_sel_i   ( lane_sel   ),
    .in_req_i   ( lane_req   ),
    .in_gnt_o   ( lane_gnt   ),
    .mem_req_o  ( mem_req_o  ),
    .mem_bank_o ( mem_bank_o ),
    .mem_gnt_i  ( mem_gnt_i  )
  );

endmodule

`default_nettype wire

// ==== verification/banked_mem_ctrl_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module banked_mem_ctrl_properties (
  input logic                                          clk_i,
  input logic                                          reset_i,
  input bank_pkg::wb_req_t   [bank_pkg::NUM_PORTS-1:0] wb_req_i,
  input bank_pkg::wb_rsp_t   [bank_pkg::NUM_PORTS-1:0] wb_rsp_o,
  input logic                [bank_pkg::NUM_BANKS-1:0] mem_req_o,
  input bank_pkg::bank_req_t [bank_pkg::NUM_BANKS-1:0] mem_bank_o,
  input logic                [bank_pkg::NUM_BANKS-1:0] mem_gnt_i
);

  // Failed assertions so far
  int unsigned fail_count = 0;

  for (genvar p = 0; p < bank_pkg::NUM_PORTS; p++) begin : gen_port
    // Ack only for an access the master still presents
    ack_in_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
      wb_rsp_o[p].ack |-> wb_req_i[p].cyc && wb_req_i[p].stb)
      else begin
        fail_count++;
        $error("port %0d ack without cyc and stb", p);
      end

    // One cycle pulse
    ack_single: assert property (@(posedge clk_i) disable iff (reset_i)
      wb_rsp_o[p].ack |=> !wb_rsp_o[p].ack)
      else begin
        fail_count++;
        $error("port %0d ack high for two cycles", p);
      end
  end

  for (genvar b = 0; b < bank_pkg::NUM_BANKS; b++) begin : gen_bank
    // Stalled bank request keeps its payload
    req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      mem_req_o[b] && !mem_gnt_i[b] |=> mem_req_o[b] && $stable(mem_bank_o[b]))
      else begin
        fail_count++;
        $error("bank %0d request changed while stalled", b);
      end
  end

endmodule

bind banked_mem_ctrl banked_mem_ctrl_properties u_properties (
  .clk_i      ( clk_i      ),
  .reset_i    ( reset_i    ),
  .wb_req_i   ( wb_req_i   ),
  .wb_rsp_o   ( wb_rsp_o   ),
  .mem_req_o  ( mem_req_o  ),
  .mem_bank_o ( mem_bank_o ),
  .mem_gnt_i  ( mem_gnt_i  )
);

`default_nettype wire

// ==== verification/tb_banked_mem_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_banked_mem_ctrl;

  localparam int unsigned CLK_PERIOD    = 8;
  localparam int unsigned RAND_OPS      = 100;
  localparam int unsigned CROSS_OPS     = 20;
  // Loose bound on the cycles of one access under random back-pressure
  localparam int unsigned ACCESS_CYCLES = 40;
  localparam int unsigned WATCHDOG_NS   =
    (2 * (RAND_OPS + CROSS_OPS) * ACCESS_CYCLES + 100) * CLK_PERIOD;
  localparam int unsigned BANK_WORDS    = 1 << bank_pkg::MEM_ADDR_WIDTH;
  localparam int unsigned BUS_WORDS     = BANK_WORDS * bank_pkg::NUM_BANKS / bank_pkg::NUM_LANES;

  logic clk_i = 1'b0;
  logic reset_i;
  bank_pkg::wb_req_t   [bank_pkg::NUM_PORTS-1:0]                wb_req;
  bank_pkg::wb_rsp_t   [bank_pkg::NUM_PORTS-1:0]                wb_rsp;
  logic                [bank_pkg::NUM_BANKS-1:0]                mem_req;
  bank_pkg::bank_req_t [bank_pkg::NUM_BANKS-1:0]                mem_bank;
  logic                [bank_pkg::NUM_BANKS-1:0]                mem_gnt;
  logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::MEM_DATA_WIDTH-1:0] mem_rdata;

  // Bank contents, and the same memory seen as 64-bit bus words
  logic [31:0] bank_mem [bank_pkg::NUM_BANKS][BANK_WORDS];
  logic [63:0] ref_mem [BUS_WORDS];
  logic [31:0] port_rng [bank_pkg::NUM_PORTS];
  int unsigned ack_count [bank_pkg::NUM_PORTS] = '{default: 0};

  banked_mem_ctrl u_banked_mem_ctrl (
    .clk_i       ( clk_i     ),
    .reset_i     ( reset_i   ),
    .wb_req_i    ( wb_req    ),
    .wb_rsp_o    ( wb_rsp    ),
    .mem_req_o   ( mem_req   ),
    .mem_bank_o  ( mem_bank  ),
    .mem_gnt_i   ( mem_gnt   ),
    .mem_rdata_i ( mem_rdata )
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Next number of one port's stimulus stream
  function automatic logic [31:0] port_rand(input int unsigned p);
    port_rng[p] = lcg(port_rng[p]);
    return port_rng[p];
  endfunction

  // Power-up word, unique to its lane byte address
  function automatic logic [31:0] fill_word(input logic [11:0] byte_addr);
    return {4'hC, byte_addr, 4'h3, ~byte_addr};
  endfunction

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("Errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  // One Wishbone classic access, held until ack
  task automatic bus_access(input int unsigned p, input logic we, input logic [15:0] adr,
                            input logic [63:0] dat, input logic [7:0] sel,
                            output logic [63:0] rdata);
    @(posedge clk_i);
    wb_req[p] <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
    // Ack is registered, look at it mid cycle
    do begin
      @(negedge clk_i);
    end while (!wb_rsp[p].ack);
    rdata = wb_rsp[p].dat;
    @(posedge clk_i);
    wb_req[p] <= '0;
  endtask

  // Access plus reference update or read check
  task automatic word_op(input int unsigned p, input logic we, input logic [15:0] adr,
                         input logic [63:0] dat, input logic [7:0] sel);
    logic [63:0] rdata;
    bus_access(p, we, adr, dat, sel, rdata);
    if (we) begin
      for (int unsigned k = 0; k < 8; k++) begin
        if (sel[k]) begin
          ref_mem[adr[11:3]][8*k +: 8] = dat[8*k +: 8];
        end
      end
    end else begin
      check_value($sformatf("port %0d read at %h", p, adr), rdata, ref_mem[adr[11:3]]);
    end
  endtask

  task automatic random_traffic(input int unsigned p);
    logic [31:0] r;
    logic [63:0] d;
    for (int unsigned n = 0; n < RAND_OPS; n++) begin
      r = port_rand(p);
      d = {port_rand(p), port_rand(p)};
      // Bit 11 splits words between ports, banks stay shared, high bits alias
      word_op(p, r[31], {r[27:24], p[0], 4'b0, r[23:20], r[19:17]}, d, r[15:8]);
    end
  endtask

  // Bank model with random grants and fixed read latency
  initial begin : bank_model
    logic [31:0] rnd;
    logic [bank_pkg::NUM_BANKS-1:0] gnt_next;
    logic [bank_pkg::NUM_BANKS-1:0][31:0] rd_pipe [bank_pkg::MEM_LATENCY];
    rnd       = 32'd5;
    mem_gnt   = '0;
    mem_rdata = '0;
    for (int unsigned b = 0; b < bank_pkg::NUM_BANKS; b++) begin
      for (int unsigned a = 0; a < BANK_WORDS; a++) begin
        bank_mem[b][a] = fill_word(12'(a * 16 + b * 4));
      end
    end
    forever begin
      @(posedge clk_i);
      for (int k = bank_pkg::MEM_LATENCY - 1; k > 0; k--) begin
        rd_pipe[k] = rd_pipe[k-1];
      end
      for (int unsigned b = 0; b < bank_pkg::NUM_BANKS; b++) begin
        rnd = lcg(rnd);
        gnt_next[b]   = |rnd[31:30];
        // Junk unless the bank is read
        rd_pipe[0][b] = rnd;
        if (mem_req[b] && mem_gnt[b]) begin
          if (mem_bank[b].we) begin
            for (int unsigned k = 0; k < 4; k++) begin
              if (mem_bank[b].be[k]) begin
                bank_mem[b][mem_bank[b].addr][8*k +: 8] = mem_bank[b].wdata[8*k +: 8];
              end
            end
          end else begin
            rd_pipe[0][b] = bank_mem[b][mem_bank[b].addr];
          end
        end
      end
      mem_gnt   <= gnt_next;
      mem_rdata <= rd_pipe[bank_pkg::MEM_LATENCY-1];
    end
  end

  always @(negedge clk_i) begin
    for (int unsigned p = 0; p < bank_pkg::NUM_PORTS; p++) begin
      if (!reset_i && wb_rsp[p].ack) begin
        ack_count[p] <= ack_count[p] + 1;
      end
    end
  end

  // Handshake assertions of the bound checker
  always @(negedge clk_i) begin
    if (u_banked_mem_ctrl.u_properties.fail_count != 0) begin
      $display("An assertion on the bus or bank handshake failed");
      $display("Errors found");
      $fatal(1, "assertion failed");
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the bus accesses did not all complete in time");
    $display("Errors found");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [31:0] r;
    reset_i = 1'b1;
    wb_req  = '0;
    for (int unsigned p = 0; p < bank_pkg::NUM_PORTS; p++) begin
      port_rng[p] = 32'd5 + 32'(p + 1) * 32'h0001_0000;
    end
    for (int unsigned w = 0; w < BUS_WORDS; w++) begin
      ref_mem[w] = {fill_word(12'(w * 8 + 4)), fill_word(12'(w * 8))};
    end
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    // Quiet bus after reset
    repeat (4) begin
      @(negedge clk_i);
      check_value("ack while idle", {wb_rsp[1].ack, wb_rsp[0].ack}, '0);
      check_value("bank request while idle", mem_req, '0);
    end
    fork
      random_traffic(0);
      random_traffic(1);
    join
    // Write on one port, read back on the other through another alias
    for (int unsigned n = 0; n < CROSS_OPS; n++) begin
      r = port_rand(0);
      word_op(n % 2, 1'b1, {r[31:28], r[11:0]}, {port_rand(0), port_rand(0)}, r[19:12]);
      word_op(1 - n % 2, 1'b0, {~r[31:28], r[11:0]}, '0, '0);
    end
    repeat (4) @(negedge clk_i);
    for (int unsigned p = 0; p < bank_pkg::NUM_PORTS; p++) begin
      check_value($sformatf("ack count of port %0d", p), ack_count[p], RAND_OPS + CROSS_OPS);
    end
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/bank_pkg.sv
rtl/wb_bank_port.sv
rtl/bank_rr_arbiter.sv
rtl/bank_xbar.sv
rtl/read_return_pipe.sv
rtl/banked_mem_ctrl.sv
verification/banked_mem_ctrl_properties.sv
verification/tb_banked_mem_ctrl.sv

// ==== Bender.yml ====
package:
  name: banked_mem_ctrl

sources:
  - rtl/bank_pkg.sv
  - rtl/wb_bank_port.sv
  - rtl/bank_rr_arbiter.sv
  - rtl/bank_xbar.sv
  - rtl/read_return_pipe.sv
  - rtl/banked_mem_ctrl.sv
  - target: test
    files:
      - verification/banked_mem_ctrl_properties.sv
      - verification/tb_banked_mem_ctrl.sv
